// ==== flist.f ====
hw/img_proc_pkg.sv
hw/pixel_lane.sv
hw/cmd_decoder.sv
hw/mem_sequencer.sv
hw/img_proc_top.sv
verification/tb_clock_gen.sv
verification/img_proc_properties.sv
verification/img_proc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the image processor testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module img_proc_tb -Mdir obj_dir -o img_proc_sim -f flist.f \
   || { echo "build failed"; exit 1; }

./obj_dir/img_proc_sim 2>&1 | tee sim.log

grep -q "Simulation FAILED" sim.log && { echo "run failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "run ended without a result, see sim.log"; exit 1; }
echo "run passed"

// ==== verification/img_proc_tb.sv ====
// image processor testbench
// host driver, word memory with random read latency, byte-level reference model
module img_proc_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import img_proc_pkg::*;

   localparam int MEM_BYTES  = 4096;
   localparam int MEM_WORDS  = MEM_BYTES / 2;
   localparam int MAX_CYCLES = 20000;   // eleven tests of under 1000 cycles each and a wide margin

   logic      clk;
   logic      reset;
   mem_addr_t addr;
   logic      wr_en;
   logic      rd_en;
   word_t     data_write;
   word_t     data_read;
   logic      data_read_valid;
   pixel_t    comm_cmd;
   pixel_t    comm_data_in;
   logic      comm_data_in_valid;
   pixel_t    comm_data_out;
   logic      comm_data_out_valid;
   logic      comm_data_out_free;

   word_t     mem [MEM_WORDS];
   pixel_t    model [MEM_BYTES];   // expected memory contents by byte address
   int        model_in;            // input buffer base
   int        model_st;            // storage buffer base
   int        npix;
   int        img_w;
   int        img_h;
   pixel_t    rx_q [$];            // bytes seen on the host output
   mem_addr_t rd_addr;
   int        rd_delay;
   logic      free_hold;
   int        cycles;
   int        checks;
   int        errors;
   int        op_add;
   logic      op_flag;             // clamp flag or threshold upper flag
   pixel_t    op_thr;
   pixel_t    op_rep;
   pixel_t    op_mul;
   pixel_t    first;

   tb_clock_gen #(.RESET_CYCLES(10)) i_clock_gen (.clk(clk), .reset(reset));

   img_proc_top #(.MEM_BYTES(MEM_BYTES)) i_dut (.*);

   always @(posedge clk) begin
      if (wr_en) mem[addr[11:1]] = data_write;   // word index into 4 KiB
   end

   always @(posedge clk) begin
      if (rd_en) begin
         rd_addr  = addr;
         rd_delay = int'($urandom_range(3, 1));
         repeat (rd_delay - 1) @(posedge clk);
         #1;
         data_read       = mem[rd_addr[11:1]];
         data_read_valid = 1'b1;
         @(posedge clk);
         #1;
         data_read_valid = 1'b0;
      end
   end

   always @(posedge clk) begin
      if (!reset && comm_data_out_valid) rx_q.push_back(comm_data_out);
   end

   always @(posedge clk) begin
      #1;
      comm_data_out_free = !free_hold && ($urandom_range(3, 0) != 0);   // free 3 of 4
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, the DUT stopped responding", cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   function automatic pixel_t expect_px(pix_op_t op, pixel_t p);
      int s;
      case (op)
         ADD: begin
            s = int'(p) + op_add;
            if (op_flag && s < 0) s = 0;
            else if (op_flag && s > 255) s = 255;
         end
         THRESHOLD: begin
            s = int'(p);
            if (op_flag ? (p >= op_thr) : (p <= op_thr)) s = int'(op_rep);
         end
         INVERT: s = int'(p) ^ 255;
         default: begin
            s = (int'(p) * int'(op_mul)) >> 4;   // 4.4 factor
            if (op_flag && s > 255) s = 255;
         end
      endcase
      return pixel_t'(s);   // low byte when no clamp applies
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic host_byte(input pixel_t cmd, input pixel_t data);
      comm_cmd           = cmd;
      comm_data_in       = data;
      comm_data_in_valid = 1'b1;
      next_cycle();
      comm_data_in_valid = 1'b0;
   endtask

   task automatic check_byte(input string name, input pixel_t exp, input pixel_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error: %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic get_byte(output pixel_t b);
      while (rx_q.size() == 0) next_cycle();
      b = rx_q.pop_front();
   endtask

   task automatic get_status(input int stall, output pixel_t lead);
      pixel_t b;
      if (stall > 0) begin
         free_hold = 1'b1;
         next_cycle();
      end
      host_byte(GET_STATUS, 8'h00);
      if (stall > 0) begin
         repeat (stall) next_cycle();
         checks++;
         if (rx_q.size() != 0) begin
            errors++;
            $display("status byte sent while the host held comm_data_out_free low");
         end
         free_hold = 1'b0;
      end
      get_byte(lead);
      get_byte(b);
      check_byte("status byte 1", 8'h22, b);
      get_byte(b);
      check_byte("status byte 2", 8'h33, b);
      get_byte(b);
      check_byte("status byte 3", 8'h44, b);
   endtask

   task automatic set_dims(input int w, input int h);
      host_byte(PARAM, 8'h00);
      host_byte(8'h00, w[7:0]);   // low byte first
      host_byte(8'h00, w[15:8]);
      host_byte(8'h00, h[7:0]);
      host_byte(8'h00, h[15:8]);
      npix     = w * h;
      model_in = 0;
      model_st = MEM_BYTES / 2;
   endtask

   task automatic send_image();
      pixel_t p;
      host_byte(SEND_IMG, 8'h00);
      for (int i = 0; i < npix; i++) begin
         p                   = pixel_t'($urandom);
         model[model_in + i] = p;
         host_byte(8'h00, p);
      end
   endtask

   task automatic read_image(input string name);
      pixel_t b;
      host_byte(READ_IMG, 8'h00);
      for (int i = 0; i < npix; i++) begin
         get_byte(b);
         check_byte(name, model[model_in + i], b);
      end
   endtask

   task automatic switch_buffers();
      int t;
      host_byte(SWITCH_BUFFERS, 8'h00);
      t        = model_in;
      model_in = model_st;
      model_st = t;
   endtask

   // first poll must catch the sweep running, then poll until idle
   task automatic wait_job(input string name);
      pixel_t lead;
      get_status(0, lead);
      check_byte({name, " busy status"}, 8'h11, lead);
      while (lead == 8'h11) get_status(0, lead);
      check_byte({name, " idle status"}, 8'h10, lead);
   endtask

   task automatic image_op_test(input string name, input pix_op_t op, input logic flag);
      set_dims(int'($urandom_range(16, 8)), int'($urandom_range(6, 4)));
      send_image();
      switch_buffers();   // sent image becomes the storage buffer
      op_flag = flag;
      op_add  = int'($urandom_range(600, 0)) - 300;
      op_thr  = pixel_t'($urandom);
      op_rep  = pixel_t'($urandom);
      op_mul  = pixel_t'($urandom_range(255, 32));   // factor of 2 or more overflows bright pixels
      case (op)
         ADD: begin
            host_byte(APPLY_ADD, 8'h00);
            host_byte(8'h00, op_add[7:0]);
            host_byte(8'h00, op_add[15:8]);
            host_byte(8'h00, {7'h00, flag});
         end
         THRESHOLD: begin
            host_byte(APPLY_THRESHOLD, 8'h00);
            host_byte(8'h00, op_thr);
            host_byte(8'h00, op_rep);
            host_byte(8'h00, {7'h00, flag});
         end
         INVERT: host_byte(APPLY_INVERT, 8'h00);
         default: begin
            host_byte(APPLY_MULT, 8'h00);
            host_byte(8'h00, op_mul);
            host_byte(8'h00, {7'h00, flag});
         end
      endcase
      for (int i = 0; i < npix; i++) model[model_st + i] = expect_px(op, model[model_st + i]);
      wait_job(name);
      switch_buffers();
      read_image(name);
   endtask

   initial begin
      void'($urandom(32'hb53c));
      comm_cmd           = 8'h00;
      comm_data_in       = 8'h00;
      comm_data_in_valid = 1'b0;
      comm_data_out_free = 1'b0;
      data_read          = '0;
      data_read_valid    = 1'b0;
      free_hold          = 1'b0;
      cycles             = 0;
      checks             = 0;
      errors             = 0;
      for (int i = 0; i < MEM_WORDS; i++) mem[i] = word_t'(i * 40503) ^ 16'h5a5a;
      @(negedge reset);
      repeat (2) next_cycle();

      get_status(20, first);   // host stalls the reply first
      check_byte("reset status", 8'h10, first);

      img_w = int'($urandom_range(16, 8));
      img_h = int'($urandom_range(6, 4));
      set_dims(img_w, img_h);
      send_image();
      read_image("loopback");
      switch_buffers();
      set_dims(img_w, img_h);   // PARAM moves both buffers back to their home addresses
      read_image("readback after param");

      image_op_test("add clamp", ADD, 1'b1);
      image_op_test("add wrap", ADD, 1'b0);
      image_op_test("threshold upper", THRESHOLD, 1'b1);
      image_op_test("threshold lower", THRESHOLD, 1'b0);
      image_op_test("invert", INVERT, 1'b0);
      image_op_test("mult clamp", MULT, 1'b1);
      image_op_test("mult wrap", MULT, 1'b0);

      host_byte(8'd11, 8'h00);   // dropped codes
      host_byte(8'd7, 8'h00);
      get_status(0, first);
      check_byte("status after dropped code", 8'h10, first);
      read_image("readback after dropped code");

      repeat (20) next_cycle();
      checks++;
      if (rx_q.size() != 0) begin
         errors++;
         $display("host received %0d bytes that no command asked for", rx_q.size());
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== verification/img_proc_properties.sv ====
// image processor port assertions
// memory port exclusivity, even write addresses and host output flow control
module img_proc_properties (
   input logic                    clk,
   input logic                    reset,
   input logic                    wr_en,
   input logic                    rd_en,
   input img_proc_pkg::mem_addr_t addr,
   input logic                    comm_data_out_valid,
   input logic                    comm_data_out_free
);
   timeunit 1ns;
   timeprecision 100ps;

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(wr_en && rd_en))
      else $error("wr_en and rd_en high in the same cycle");

   // words are two bytes, so writes land on even byte addresses
   a_wr_even: assert property (@(posedge clk) disable iff (reset) wr_en |-> !addr[0])
      else $error("write to odd address %h", addr);

   a_out_free: assert property (@(posedge clk) disable iff (reset)
      comm_data_out_valid |-> $past(comm_data_out_free))
      else $error("host byte sent without comm_data_out_free in the cycle before");

endmodule

bind img_proc_top img_proc_properties i_properties (
   .clk                (clk),
   .reset              (reset),
   .wr_en              (wr_en),
   .rd_en              (rd_en),
   .addr               (addr),
   .comm_data_out_valid(comm_data_out_valid),
   .comm_data_out_free (comm_data_out_free)
);

// ==== verification/tb_clock_gen.sv ====
// testbench clock and reset source
// 8 ns clock, reset held high for the first cycles
module tb_clock_gen #(
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;   // released with the other stimulus
   end

endmodule

// ==== hw/img_proc_top.sv ====
// image processor top level
// command decoder, memory sequencer and one pixel lane per byte of a word
module img_proc_top #(
   parameter int unsigned MEM_BYTES = 131072
) (
   input  logic                    clk,
   input  logic                    reset,
   output img_proc_pkg::mem_addr_t addr,
   output logic                    wr_en,
   output logic                    rd_en,
   output img_proc_pkg::word_t     data_write,
   input  img_proc_pkg::word_t     data_read,
   input  logic                    data_read_valid,
   input  img_proc_pkg::pixel_t    comm_cmd,
   input  img_proc_pkg::pixel_t    comm_data_in,
   input  logic                    comm_data_in_valid,
   output img_proc_pkg::pixel_t    comm_data_out,
   output logic                    comm_data_out_valid,
   input  logic                    comm_data_out_free
);
   import img_proc_pkg::*;

   job_t             job;
   logic             job_start;
   logic             job_busy;
   word_t            wr_word;
   logic             wr_word_valid;
   word_t            rd_word;
   logic             word_ready;
   logic             word_taken;
   op_cfg_t          op_cfg;
   logic             lane_load;
   word_t            lane_word;    // lane 0 in the low byte
   logic [LANES-1:0] lane_valid;

   cmd_decoder #(
      .MEM_BYTES(MEM_BYTES)
   ) i_cmd_decoder (
      .clk                (clk),
      .reset              (reset),
      .comm_cmd           (comm_cmd),
      .comm_data_in       (comm_data_in),
      .comm_data_in_valid (comm_data_in_valid),
      .comm_data_out      (comm_data_out),
      .comm_data_out_valid(comm_data_out_valid),
      .comm_data_out_free (comm_data_out_free),
      .job                (job),
      .job_start          (job_start),
      .job_busy           (job_busy),
      .wr_word            (wr_word),
      .wr_word_valid      (wr_word_valid),
      .rd_word            (rd_word),
      .word_ready         (word_ready),
      .word_taken         (word_taken),
      .op_cfg             (op_cfg)
   );

   for (genvar i = 0; i < LANES; i++) begin : g_lane
      pixel_lane i_pixel_lane (
         .clk         (clk),
         .reset       (reset),
         .op_cfg      (op_cfg),
         .pixel_in    (data_read[i*PIX_W +: PIX_W]),
         .lane_load   (lane_load),
         .result      (lane_word[i*PIX_W +: PIX_W]),
         .result_valid(lane_valid[i])
      );
   end

   mem_sequencer i_mem_sequencer (
      .clk              (clk),
      .reset            (reset),
      .job              (job),
      .job_start        (job_start),
      .job_busy         (job_busy),
      .wr_word          (wr_word),
      .wr_word_valid    (wr_word_valid),
      .rd_word          (rd_word),
      .word_ready       (word_ready),
      .word_taken       (word_taken),
      .lane_load        (lane_load),
      .lane_result      (lane_word),
      .lane_result_valid(&lane_valid),
      .addr             (addr),
      .wr_en            (wr_en),
      .rd_en            (rd_en),
      .data_write       (data_write),
      .data_read        (data_read),
      .data_read_valid  (data_read_valid)
   );

endmodule

// ==== hw/mem_sequencer.sv ====
// memory sequencer
// owns the external memory port and runs one job at a time: image writes
// from the host, image reads to the host and in-place processing sweeps
module mem_sequencer (
   input  logic                    clk,
   input  logic                    reset,
   input  img_proc_pkg::job_t      job,
   input  logic                    job_start,
   output logic                    job_busy,
   input  img_proc_pkg::word_t     wr_word,
   input  logic                    wr_word_valid,
   output img_proc_pkg::word_t     rd_word,
   output logic                    word_ready,
   input  logic                    word_taken,
   output logic                    lane_load,
   input  img_proc_pkg::word_t     lane_result,
   input  logic                    lane_result_valid,
   output img_proc_pkg::mem_addr_t addr,
   output logic                    wr_en,
   output logic                    rd_en,
   output img_proc_pkg::word_t     data_write,
   input  img_proc_pkg::word_t     data_read,
   input  logic                    data_read_valid
);
   import img_proc_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      WR_WAIT,   // waiting for a packed host word
      RD_REQ,
      RD_WAIT,
      HOLD,      // word offered to the decoder
      LANE       // lanes working on the word
   } mem_state_t;

   mem_state_t state;
   job_kind_t  kind;
   mem_addr_t  cur_addr;
   dim_t       words_left;
   logic       last_word;
   logic       advance;   // current word is done

   assign last_word = (words_left == dim_t'(1));
   assign lane_load = (state == RD_WAIT) && data_read_valid && (kind == PROCESS);
   assign advance   = (state == WR_WAIT && wr_word_valid)
                      || (state == HOLD && word_taken)
                      || (state == LANE && lane_result_valid);

   always_ff @(posedge clk) begin
      wr_en <= 1'b0;
      rd_en <= 1'b0;
      if (reset) begin
         state      <= IDLE;
         job_busy   <= 1'b0;
         word_ready <= 1'b0;
      end else begin
         if (advance) begin
            cur_addr   <= cur_addr + mem_addr_t'(2);
            words_left <= words_left - 1'b1;
         end
         case (state)
            IDLE: if (job_start) begin
               kind       <= job.kind;
               cur_addr   <= job.base;
               words_left <= job.words;
               job_busy   <= 1'b1;
               state      <= (job.kind == WRITE_IN) ? WR_WAIT : RD_REQ;
            end
            WR_WAIT: if (wr_word_valid) begin
               wr_en      <= 1'b1;
               addr       <= cur_addr;
               data_write <= wr_word;
               if (last_word) begin
                  job_busy <= 1'b0;
                  state    <= IDLE;
               end
            end
            RD_REQ: begin
               rd_en <= 1'b1;
               addr  <= cur_addr;
               state <= RD_WAIT;
            end
            RD_WAIT: if (data_read_valid) begin
               if (kind == PROCESS) begin
                  state <= LANE;   // lanes capture data_read this cycle
               end else begin
                  rd_word    <= data_read;
                  word_ready <= 1'b1;
                  state      <= HOLD;
               end
            end
            HOLD: if (word_taken) begin
               word_ready <= 1'b0;
               if (last_word) begin
                  job_busy <= 1'b0;
                  state    <= IDLE;
               end else begin
                  state <= RD_REQ;
               end
            end
            LANE: if (lane_result_valid) begin
               wr_en      <= 1'b1;   // back to the address it came from
               addr       <= cur_addr;
               data_write <= lane_result;
               if (last_word) begin
                  job_busy <= 1'b0;
                  state    <= IDLE;
               end else begin
                  state <= RD_REQ;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

// ==== hw/cmd_decoder.sv ====
// host command decoder
// parses the byte-wide command port, keeps image and operation settings,
// starts memory jobs and serializes status and image bytes to the host
module cmd_decoder #(
   parameter int unsigned MEM_BYTES = 131072
) (
   input  logic                  clk,
   input  logic                  reset,
   input  img_proc_pkg::pixel_t  comm_cmd,
   input  img_proc_pkg::pixel_t  comm_data_in,
   input  logic                  comm_data_in_valid,
   output img_proc_pkg::pixel_t  comm_data_out,
   output logic                  comm_data_out_valid,
   input  logic                  comm_data_out_free,
   output img_proc_pkg::job_t    job,
   output logic                  job_start,
   input  logic                  job_busy,
   output img_proc_pkg::word_t   wr_word,
   output logic                  wr_word_valid,
   input  img_proc_pkg::word_t   rd_word,
   input  logic                  word_ready,
   output logic                  word_taken,
   output img_proc_pkg::op_cfg_t op_cfg
);
   import img_proc_pkg::*;

   typedef enum logic [2:0] {
      WAIT_CMD,
      GET_DIMS,
      SEND_PIX,
      READ_PIX,
      STATUS,
      OP_ARGS
   } cmd_state_t;

   localparam mem_addr_t ST_BASE = mem_addr_t'(MEM_BYTES / 2);

   cmd_state_t state;
   dim_t       cnt;          // byte or pixel index within the command
   dim_t       width;
   dim_t       height;
   mem_addr_t  in_base;
   mem_addr_t  st_base;
   pixel_t     lo_byte;      // even pixel waiting for its partner
   dim_t       n_pix;
   dim_t       n_words;
   logic       last_pix;
   logic       arg_last;
   pixel_t     status_byte;

   assign n_pix    = dim_t'(width * height);
   assign n_words  = dim_t'((32'(n_pix) + 32'd1) >> 1);   // odd count rounds up
   assign last_pix = (cnt == n_pix - dim_t'(1));
   assign arg_last = (op_cfg.op == MULT) ? (cnt == dim_t'(1)) : (cnt == dim_t'(2));

   // pixel pairs go straight to the sequencer, a lone last pixel too
   assign wr_word_valid = (state == SEND_PIX) && comm_data_in_valid && (cnt[0] || last_pix);
   assign wr_word       = cnt[0] ? {comm_data_in, lo_byte} : {8'h00, comm_data_in};
   assign word_taken    = (state == READ_PIX) && word_ready && comm_data_out_free
                          && (cnt[0] || last_pix);

   always_comb begin
      case (cnt[1:0])
         2'd0:    status_byte = {7'h08, job_busy};   // 8'h10 idle, 8'h11 busy
         2'd1:    status_byte = 8'h22;
         2'd2:    status_byte = 8'h33;
         default: status_byte = 8'h44;
      endcase
   end

   always_ff @(posedge clk) begin
      job_start           <= 1'b0;
      comm_data_out_valid <= 1'b0;
      if (reset) begin
         state   <= WAIT_CMD;
         cnt     <= '0;
         width   <= '0;
         height  <= '0;
         in_base <= '0;
         st_base <= ST_BASE;
      end else begin
         case (state)
            WAIT_CMD: if (comm_data_in_valid) begin
               cnt <= '0;
               if (cmd_code_t'(comm_cmd) == GET_STATUS) begin
                  state <= STATUS;   // the only command taken while busy
               end else if (!job_busy) begin
                  case (cmd_code_t'(comm_cmd))
                     PARAM: begin
                        state   <= GET_DIMS;
                        in_base <= '0;
                        st_base <= ST_BASE;
                     end
                     SEND_IMG: if (n_pix != '0) begin
                        job       <= '{kind: WRITE_IN, base: in_base, words: n_words};
                        job_start <= 1'b1;
                        state     <= SEND_PIX;
                     end
                     READ_IMG: if (n_pix != '0) begin
                        job       <= '{kind: READ_OUT, base: in_base, words: n_words};
                        job_start <= 1'b1;
                        state     <= READ_PIX;
                     end
                     SWITCH_BUFFERS: begin
                        in_base <= st_base;
                        st_base <= in_base;
                     end
                     APPLY_ADD: begin
                        op_cfg.op <= ADD;
                        state     <= OP_ARGS;
                     end
                     APPLY_THRESHOLD: begin
                        op_cfg.op <= THRESHOLD;
                        state     <= OP_ARGS;
                     end
                     APPLY_MULT: begin
                        op_cfg.op <= MULT;
                        state     <= OP_ARGS;
                     end
                     APPLY_INVERT: begin   // no arguments, starts at once
                        op_cfg.op <= INVERT;
                        job       <= '{kind: PROCESS, base: st_base, words: n_words};
                        job_start <= (n_pix != '0);
                     end
                     default: ;   // unknown or dropped code
                  endcase
               end
            end
            GET_DIMS: if (comm_data_in_valid) begin
               cnt <= cnt + 1'b1;
               case (cnt[1:0])
                  2'd0: width[7:0]  <= comm_data_in;   // low byte first
                  2'd1: width[15:8] <= comm_data_in;
                  2'd2: height[7:0] <= comm_data_in;
                  default: begin
                     height[15:8] <= comm_data_in;
                     state        <= WAIT_CMD;
                  end
               endcase
            end
            OP_ARGS: if (comm_data_in_valid) begin
               cnt <= cnt + 1'b1;
               case (op_cfg.op)
                  ADD: case (cnt[1:0])
                     2'd0:    op_cfg.add_value[7:0]  <= comm_data_in;
                     2'd1:    op_cfg.add_value[15:8] <= comm_data_in;
                     default: op_cfg.clamp           <= comm_data_in[0];
                  endcase
                  THRESHOLD: case (cnt[1:0])
                     2'd0:    op_cfg.thr_value   <= comm_data_in;
                     2'd1:    op_cfg.thr_replace <= comm_data_in;
                     default: op_cfg.thr_upper   <= comm_data_in[0];
                  endcase
                  default: begin   // mult: factor then clamp flag
                     if (cnt == '0) op_cfg.mult_value <= comm_data_in;
                     else           op_cfg.clamp      <= comm_data_in[0];
                  end
               endcase
               if (arg_last) begin
                  job       <= '{kind: PROCESS, base: st_base, words: n_words};
                  job_start <= (n_pix != '0);
                  state     <= WAIT_CMD;
               end
            end
            SEND_PIX: if (comm_data_in_valid) begin
               lo_byte <= comm_data_in;
               cnt     <= cnt + 1'b1;
               if (last_pix) state <= WAIT_CMD;
            end
            READ_PIX: if (word_ready && comm_data_out_free) begin
               comm_data_out       <= cnt[0] ? rd_word[15:8] : rd_word[7:0];
               comm_data_out_valid <= 1'b1;
               cnt                 <= cnt + 1'b1;
               if (last_pix) state <= WAIT_CMD;
            end
            STATUS: if (comm_data_out_free) begin
               comm_data_out       <= status_byte;
               comm_data_out_valid <= 1'b1;
               cnt                 <= cnt + 1'b1;
               if (cnt[1:0] == 2'd3) state <= WAIT_CMD;
            end
            default: state <= WAIT_CMD;
         endcase
      end
   end

endmodule

// ==== hw/pixel_lane.sv ====
// pixel lane
// applies the configured operation to one pixel of a memory word, registered
module pixel_lane (
   input  logic                  clk,
   input  logic                  reset,
   input  img_proc_pkg::op_cfg_t op_cfg,
   input  img_proc_pkg::pixel_t  pixel_in,
   input  logic                  lane_load,
   output img_proc_pkg::pixel_t  result,
   output logic                  result_valid
);
   import img_proc_pkg::*;

   logic signed [15:0] sum;    // pixel plus signed add value
   logic [15:0]        prod;   // integer pixel times 4.4 factor
   pixel_t             next_px;

   assign sum  = $signed({8'h00, pixel_in}) + op_cfg.add_value;
   assign prod = pixel_in * op_cfg.mult_value;

   always_comb begin
      case (op_cfg.op)
         ADD: begin
            if (op_cfg.clamp && sum < 0)
               next_px = '0;
            else if (op_cfg.clamp && sum > 16'sd255)
               next_px = 8'hff;
            else
               next_px = sum[7:0];   // wraps when clamp is off
         end
         THRESHOLD: begin
            next_px = pixel_in;
            if (op_cfg.thr_upper ? (pixel_in >= op_cfg.thr_value)
                                 : (pixel_in <= op_cfg.thr_value))
               next_px = op_cfg.thr_replace;
         end
         INVERT: next_px = ~pixel_in;
         default: begin
            // drop the 4 fraction bits, saturate anything above 255
            if (op_cfg.clamp && prod[15:12] != 4'h0)
               next_px = 8'hff;
            else
               next_px = prod[11:4];
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) result_valid <= 1'b0;
      else       result_valid <= lane_load;
      if (lane_load) result <= next_px;
   end

endmodule

// ==== hw/img_proc_pkg.sv ====
// image processor shared definitions
// pixel and memory word types, host command codes, lane settings and job records
package img_proc_pkg;

   localparam int PIX_W  = 8;
   localparam int WORD_W = 16;
   localparam int ADDR_W = 32;
   localparam int DIM_W  = 16;
   localparam int LANES  = WORD_W / PIX_W;   // pixels per memory word

   typedef logic [PIX_W-1:0]  pixel_t;
   typedef logic [WORD_W-1:0] word_t;       // even pixel in the low byte
   typedef logic [ADDR_W-1:0] mem_addr_t;   // byte address
   typedef logic [DIM_W-1:0]  dim_t;

   // host command codes, the gaps belong to functions not built here
   typedef enum logic [7:0] {
      PARAM           = 8'd0,
      SEND_IMG        = 8'd1,
      READ_IMG        = 8'd2,
      GET_STATUS      = 8'd3,
      APPLY_ADD       = 8'd4,
      APPLY_THRESHOLD = 8'd5,
      SWITCH_BUFFERS  = 8'd6,
      APPLY_INVERT    = 8'd8,
      APPLY_MULT      = 8'd14
   } cmd_code_t;

   typedef enum logic [1:0] {
      ADD,
      THRESHOLD,
      INVERT,
      MULT
   } pix_op_t;

   typedef struct packed {
      pix_op_t            op;
      logic signed [15:0] add_value;
      logic               clamp;        // add and mult
      pixel_t             thr_value;
      pixel_t             thr_replace;
      logic               thr_upper;    // replace at or above the value
      pixel_t             mult_value;   // 4.4 fixed point
   } op_cfg_t;

   typedef enum logic [1:0] {
      WRITE_IN,
      READ_OUT,
      PROCESS
   } job_kind_t;

   typedef struct packed {
      job_kind_t kind;
      mem_addr_t base;
      dim_t      words;
   } job_t;

endpackage
